/* rtl/enc_cfg.svh */
`ifndef ENC_CFG_SVH
`define ENC_CFG_SVH

// kernel and output geometry
`define ENC_KERNEL_SIZE 8
`define ENC_LENGTH_OUT  64
`define ENC_CHANNEL_OUT 32

// activation window
`define ENC_DATA_W      12
`define ENC_SPAD_DEPTH  8
`define ENC_PAD_PRE     3   // zeros ahead of column 0
`define ENC_PAD_POST    1   // zeros after the last column

// weight sram
`define ENC_SRAM_AW     10
`define ENC_SRAM_DW     32
`define ENC_SCALE_W     16

// result path and activation sram
`define ENC_OUT_W       8
`define ENC_ACT_AW      13
`define ENC_ACT_BASE    0

// scratchpad tap index width
`define ENC_TAP_W       ($clog2(`ENC_KERNEL_SIZE))

`endif

/* rtl/enc_pkg.sv */
`default_nettype none
`include "enc_cfg.svh"

package enc_pkg;

    typedef enum logic [2:0] {
        ph_idle, ph_load_wb, ph_load_a, ph_mac,
        ph_add_b, ph_requant, ph_drain, ph_done
    } phase_t;

    // datapath opcode, same codes the mac array decodes
    typedef enum logic [1:0] {
        op_none = 2'b00, op_acc = 2'b01, op_requant = 2'b10, op_add_bias = 2'b11
    } mac_op_t;

    typedef enum logic [1:0] {
        sh_none = 2'b00, sh_step = 2'b01, sh_first = 2'b10, sh_last = 2'b11
    } shift_t;

    // one weight sram word, coefficient or scale entry
    typedef union packed {
        logic signed [`ENC_SRAM_DW-1:0] coef;      // weights and bias
        struct packed {
            logic [`ENC_SRAM_DW-`ENC_SCALE_W-1:0] rsvd;
            logic signed [`ENC_SCALE_W-1:0]       scale;
        } sc;
    } sram_word_t;

endpackage

`default_nettype wire

/* rtl/enc_seq_if.sv */
`timescale 1ns/1ps
`default_nettype none

// sequencer state shared with the loaders and write-back
interface enc_seq_if;

    enc_pkg::phase_t phase;
    logic            first_col;   // column 0 of the channel
    logic            last_col;    // final column of the channel
    logic            wb_done;     // weights, bias and scale in place

    modport seq (
        output phase, first_col, last_col,
        input  wb_done
    );

    modport unit (
        input  phase, first_col, last_col,
        output wb_done
    );

endinterface

`default_nettype wire

/* rtl/enc_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_sequencer (
    input  wire                    wclk,
    input  wire                    rst_n,
    input  wire                    start,
    enc_seq_if.seq                 seq,
    output enc_pkg::mac_op_t       mac_op,
    output logic                   relu_en,
    output logic                   round_en,
    output logic [`ENC_TAP_W-1:0]  spad_rd_addr,
    output logic                   encoder_done
);
    localparam int K   = `ENC_KERNEL_SIZE;
    localparam int TW  = `ENC_TAP_W;
    localparam int KW  = $clog2(K + 1);
    localparam int LW  = $clog2(`ENC_LENGTH_OUT);
    localparam int CW  = $clog2(`ENC_CHANNEL_OUT);
    localparam logic [KW-1:0] TAP_END  = KW'(K);
    localparam logic [KW-1:0] TAP_SAT  = KW'(K - 1);
    localparam logic [LW-1:0] COL_LAST = LW'(`ENC_LENGTH_OUT - 1);
    localparam logic [CW-1:0] CH_LAST  = CW'(`ENC_CHANNEL_OUT - 1);

    enc_pkg::phase_t  phase, phase_nxt;
    enc_pkg::mac_op_t mac_op_d;
    logic [KW-1:0]    tap_cnt;   // K+1 mac cycles per column
    logic [LW-1:0]    col_cnt;
    logic [CW-1:0]    ch_cnt;

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n)
            phase <= enc_pkg::ph_idle;
        else
            phase <= phase_nxt;
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            enc_pkg::ph_idle:    if (start) phase_nxt = enc_pkg::ph_load_wb;
            enc_pkg::ph_load_wb: if (seq.wb_done) phase_nxt = enc_pkg::ph_load_a;
            enc_pkg::ph_load_a:  phase_nxt = enc_pkg::ph_mac;
            enc_pkg::ph_mac:     if (tap_cnt == TAP_END) phase_nxt = enc_pkg::ph_add_b;
            enc_pkg::ph_add_b:   phase_nxt = enc_pkg::ph_requant;
            enc_pkg::ph_requant: begin
                if (!seq.last_col)
                    phase_nxt = enc_pkg::ph_load_a;
                else if (ch_cnt != CH_LAST)
                    phase_nxt = enc_pkg::ph_load_wb;   // next channel
                else
                    phase_nxt = enc_pkg::ph_drain;     // let the last write land
            end
            enc_pkg::ph_drain:   phase_nxt = enc_pkg::ph_done;
            default:             phase_nxt = enc_pkg::ph_idle;
        endcase
    end

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt <= '0;
            col_cnt <= '0;
            ch_cnt  <= '0;
        end else begin
            tap_cnt <= (phase == enc_pkg::ph_mac && tap_cnt != TAP_END) ? tap_cnt + 1'b1 : '0;
            if (phase == enc_pkg::ph_idle) begin
                col_cnt <= '0;
                ch_cnt  <= '0;
            end else if (phase == enc_pkg::ph_requant) begin
                if (seq.last_col) begin
                    col_cnt <= '0;
                    ch_cnt  <= (ch_cnt == CH_LAST) ? '0 : ch_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (phase)
            enc_pkg::ph_mac:     mac_op = enc_pkg::op_acc;
            enc_pkg::ph_add_b:   mac_op = enc_pkg::op_add_bias;
            enc_pkg::ph_requant: mac_op = enc_pkg::op_requant;
            default:             mac_op = enc_pkg::op_none;
        endcase
    end

    // post-processing strobes trail the opcode by one cycle
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n)
            mac_op_d <= enc_pkg::op_none;
        else
            mac_op_d <= mac_op;
    end

    assign relu_en      = (mac_op_d == enc_pkg::op_add_bias);
    assign round_en     = (mac_op_d == enc_pkg::op_requant);
    assign spad_rd_addr = (tap_cnt >= TAP_SAT) ? TW'(TAP_SAT) : TW'(tap_cnt); // holds at K-1
    assign encoder_done = (phase == enc_pkg::ph_done);

    assign seq.phase     = phase;
    assign seq.first_col = (col_cnt == '0);
    assign seq.last_col  = (col_cnt == COL_LAST);

endmodule

`default_nettype wire

/* rtl/enc_wb_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_wb_loader (
    input  wire                             wclk,
    input  wire                             rst_n,
    enc_seq_if.unit                         seq,
    input  wire [`ENC_SRAM_AW-1:0]          w_base,
    input  wire [`ENC_SRAM_AW-1:0]          b_base,
    input  wire [`ENC_SRAM_AW-1:0]          scale_addr,
    input  wire enc_pkg::sram_word_t        sram_dout,
    output logic [`ENC_SRAM_AW-1:0]         sram_addr,
    output logic                            sram_en,
    output logic                            spad_w_we,
    output logic [`ENC_TAP_W-1:0]           spad_w_addr,
    output logic signed [`ENC_SRAM_DW-1:0]  spad_w_data,
    output logic signed [`ENC_SRAM_DW-1:0]  bias,
    output logic signed [`ENC_SCALE_W-1:0]  scale
);
    localparam int K  = `ENC_KERNEL_SIZE;
    localparam int AW = `ENC_SRAM_AW;
    localparam int TW = `ENC_TAP_W;
    localparam int NW = $clog2(K + 3);
    localparam logic [NW-1:0] CNT_BIAS  = NW'(K);       // bias read issued
    localparam logic [NW-1:0] CNT_SCALE = NW'(K + 1);   // scale read issued
    localparam logic [NW-1:0] CNT_LAST  = NW'(K + 2);

    logic [NW-1:0]                 wb_cnt;
    logic [AW-1:0]                 w_ptr;    // this channel's first weight
    logic [AW-1:0]                 b_ptr;
    logic signed [`ENC_SRAM_DW-1:0] bias_q;
    logic signed [`ENC_SCALE_W-1:0] scale_q;
    logic                          in_load;
    logic                          cap_bias;
    logic                          cap_scale;

    assign in_load   = (seq.phase == enc_pkg::ph_load_wb);
    assign cap_bias  = in_load && (wb_cnt == CNT_SCALE);   // bias word on the bus
    assign cap_scale = in_load && (wb_cnt == CNT_LAST);
    assign seq.wb_done = cap_scale;

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n)
            wb_cnt <= '0;
        else if (!in_load)
            wb_cnt <= '0;
        else if (wb_cnt != CNT_LAST)
            wb_cnt <= wb_cnt + 1'b1;
    end

    // read order: K weights, bias, scale
    always_comb begin
        if (wb_cnt < CNT_BIAS)
            sram_addr = w_ptr + AW'(wb_cnt);
        else if (wb_cnt == CNT_BIAS)
            sram_addr = b_ptr;
        else
            sram_addr = scale_addr;
    end

    assign sram_en     = in_load && (wb_cnt <= CNT_SCALE);
    assign spad_w_we   = in_load && (wb_cnt != '0) && (wb_cnt <= CNT_BIAS);
    assign spad_w_addr = TW'(wb_cnt - 1'b1);
    assign spad_w_data = sram_dout.coef;

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr   <= '0;
            b_ptr   <= '0;
            bias_q  <= '0;
            scale_q <= '0;
        end else begin
            if (seq.phase == enc_pkg::ph_idle) begin
                w_ptr <= w_base;
                b_ptr <= b_base;
            end else if (seq.wb_done) begin
                w_ptr <= w_ptr + AW'(K);
                b_ptr <= b_ptr + 1'b1;
            end
            if (cap_bias)
                bias_q <= sram_dout.coef;
            if (cap_scale)
                scale_q <= sram_dout.sc.scale;
        end
    end

    // pass the word straight through in its capture cycle
    assign bias  = cap_bias  ? sram_dout.coef     : bias_q;
    assign scale = cap_scale ? sram_dout.sc.scale : scale_q;

endmodule

`default_nettype wire

/* rtl/enc_act_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_act_loader (
    input  wire                                          wclk,
    input  wire                                          rst_n,
    enc_seq_if.unit                                      seq,
    input  wire [`ENC_SPAD_DEPTH-1:0][`ENC_DATA_W-1:0]   window_in,
    output enc_pkg::shift_t                              shift_en,
    output logic [`ENC_SPAD_DEPTH-1:0][`ENC_DATA_W-1:0]  window
);
    localparam int D    = `ENC_SPAD_DEPTH;
    localparam int W    = `ENC_DATA_W;
    localparam int PRE  = `ENC_PAD_PRE;
    localparam int POST = `ENC_PAD_POST;

    // window and shift request are held for the whole column
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            shift_en <= enc_pkg::sh_none;
            window   <= '0;
        end else if (seq.phase == enc_pkg::ph_load_a) begin
            if (seq.first_col) begin
                shift_en <= enc_pkg::sh_first;
                window   <= {window_in[D-PRE-1:0], {(PRE*W){1'b0}}};   // leading pad
            end else if (seq.last_col) begin
                shift_en <= enc_pkg::sh_last;
                window   <= {{(POST*W){1'b0}}, window_in[D-POST-1:0]}; // trailing pad
            end else begin
                shift_en <= enc_pkg::sh_step;
                window   <= window_in;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/enc_writeback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_writeback (
    input  wire                           wclk,
    input  wire                           rst_n,
    enc_seq_if.unit                       seq,
    input  wire signed [`ENC_OUT_W-1:0]   encoder_out,
    output logic                          out_vld,
    output logic [`ENC_ACT_AW-1:0]        act_addr,
    output logic [`ENC_OUT_W-1:0]         act_din,
    output logic                          act_we
);
    localparam int AW = `ENC_ACT_AW;
    localparam logic [AW-1:0] ACT_BASE = AW'(`ENC_ACT_BASE);

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld  <= 1'b0;
            act_we   <= 1'b0;
            act_din  <= '0;
            act_addr <= ACT_BASE;
        end else begin
            out_vld <= (seq.phase == enc_pkg::ph_requant);   // result ready next cycle
            act_we  <= out_vld;
            if (out_vld)
                act_din <= encoder_out;
            if (act_we)
                act_addr <= act_addr + 1'b1;   // consecutive results
            else if (seq.phase == enc_pkg::ph_idle)
                act_addr <= ACT_BASE;
        end
    end

endmodule

`default_nettype wire

/* rtl/enc_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_top (
    input  wire                                          wclk,
    input  wire                                          rst_n,
    input  wire                                          start,
    // weight sram
    input  wire [`ENC_SRAM_AW-1:0]                       w_base,
    input  wire [`ENC_SRAM_AW-1:0]                       b_base,
    input  wire [`ENC_SRAM_AW-1:0]                       scale_addr,
    input  wire enc_pkg::sram_word_t                     sram_dout,
    output logic [`ENC_SRAM_AW-1:0]                      sram_addr,
    output logic                                         sram_en,
    // weight scratchpad and datapath constants
    output logic                                         spad_w_we,
    output logic [`ENC_TAP_W-1:0]                        spad_w_addr,
    output logic signed [`ENC_SRAM_DW-1:0]               spad_w_data,
    output logic signed [`ENC_SRAM_DW-1:0]               bias,
    output logic signed [`ENC_SCALE_W-1:0]               scale,
    // datapath control
    output logic [`ENC_TAP_W-1:0]                        spad_rd_addr,
    output enc_pkg::mac_op_t                             mac_op,
    output logic                                         relu_en,
    output logic                                         round_en,
    // activation window
    input  wire [`ENC_SPAD_DEPTH-1:0][`ENC_DATA_W-1:0]   window_in,
    output enc_pkg::shift_t                              shift_en,
    output logic [`ENC_SPAD_DEPTH-1:0][`ENC_DATA_W-1:0]  window,
    // result write-back
    input  wire signed [`ENC_OUT_W-1:0]                  encoder_out,
    output logic                                         out_vld,
    output logic [`ENC_ACT_AW-1:0]                       act_addr,
    output logic [`ENC_OUT_W-1:0]                        act_din,
    output logic                                         act_we,
    output logic                                         encoder_done
);

    enc_seq_if seq_bus ();

    enc_sequencer u_seq (
        .wclk         (wclk),
        .rst_n        (rst_n),
        .start        (start),
        .seq          (seq_bus.seq),
        .mac_op       (mac_op),
        .relu_en      (relu_en),
        .round_en     (round_en),
        .spad_rd_addr (spad_rd_addr),
        .encoder_done (encoder_done)
    );

    enc_wb_loader u_wb (
        .wclk        (wclk),
        .rst_n       (rst_n),
        .seq         (seq_bus.unit),
        .w_base      (w_base),
        .b_base      (b_base),
        .scale_addr  (scale_addr),
        .sram_dout   (sram_dout),
        .sram_addr   (sram_addr),
        .sram_en     (sram_en),
        .spad_w_we   (spad_w_we),
        .spad_w_addr (spad_w_addr),
        .spad_w_data (spad_w_data),
        .bias        (bias),
        .scale       (scale)
    );

    enc_act_loader u_act (
        .wclk      (wclk),
        .rst_n     (rst_n),
        .seq       (seq_bus.unit),
        .window_in (window_in),
        .shift_en  (shift_en),
        .window    (window)
    );

    enc_writeback u_wbk (
        .wclk        (wclk),
        .rst_n       (rst_n),
        .seq         (seq_bus.unit),
        .encoder_out (encoder_out),
        .out_vld     (out_vld),
        .act_addr    (act_addr),
        .act_din     (act_din),
        .act_we      (act_we)
    );

endmodule

`default_nettype wire

/* verif/enc_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module enc_sva (
    input wire             wclk,
    input wire             rst_n,
    input wire             relu_en,
    input wire             round_en,
    input wire             encoder_done,
    input wire             out_vld,
    input wire             act_we,
    input wire             sram_en,
    input enc_pkg::phase_t phase
);

    // post-processing strobes never overlap
    a_strobe_onehot: assert property (@(posedge wclk) disable iff (!rst_n)
        $onehot0({relu_en, round_en, encoder_done}))
        else $error("relu, round and done strobes overlap");

    // a write sits alone in the cycle right after out_vld
    a_we_only_after_vld: assert property (@(posedge wclk) disable iff (!rst_n)
        act_we |-> $past(out_vld) && !out_vld)
        else $error("act_we not in the cycle right after out_vld");

    // read data lands before the loader leaves load_wb
    a_sram_in_load: assert property (@(posedge wclk) disable iff (!rst_n)
        (sram_en || $past(sram_en)) |-> (phase == enc_pkg::ph_load_wb))
        else $error("sram read or its data outside load_wb");

endmodule

`default_nettype wire

/* verif/enc_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_cfg.svh"

module enc_tb;
    localparam int K  = `ENC_KERNEL_SIZE;
    localparam int LO = `ENC_LENGTH_OUT;
    localparam int CH = `ENC_CHANNEL_OUT;
    localparam int D  = `ENC_SPAD_DEPTH;
    localparam int W  = `ENC_DATA_W;
    localparam int RUN_CYC = CH * (K + 3 + LO * (K + 4));
    localparam int RUNS = 2;

    logic wclk = 1'b0;
    logic rst_n, start;
    logic [`ENC_SRAM_AW-1:0] w_base, b_base, scale_addr, sram_addr, rd_addr_q;
    enc_pkg::sram_word_t sram_dout;
    logic sram_en, spad_w_we, relu_en, round_en, out_vld, act_we, encoder_done;
    logic [`ENC_TAP_W-1:0] spad_w_addr, spad_rd_addr;
    logic signed [`ENC_SRAM_DW-1:0] spad_w_data, bias;
    logic signed [`ENC_SCALE_W-1:0] scale;
    enc_pkg::mac_op_t mac_op, prev_op;
    enc_pkg::shift_t shift_en;
    logic [D-1:0][W-1:0] window_in, window, win_nxt;
    logic signed [`ENC_OUT_W-1:0] encoder_out;
    logic [`ENC_OUT_W-1:0] out_nxt;
    logic [`ENC_ACT_AW-1:0] act_addr;
    logic [`ENC_OUT_W-1:0] act_din;
    logic [31:0] mem [0:(1<<`ENC_SRAM_AW)-1];
    logic [7:0] exp_q [$];
    integer seed = 32'h674f;
    int err_cnt = 0, chk_cnt = 0, done_cnt = 0;
    int ch_i, col_i, wk, acc_cnt, wr_cnt, cyc, last_rq_cyc;

    enc_top dut (.*);

    bind enc_top enc_sva u_sva (
        .wclk(wclk), .rst_n(rst_n), .relu_en(relu_en), .round_en(round_en),
        .encoder_done(encoder_done), .out_vld(out_vld), .act_we(act_we),
        .sram_en(sram_en), .phase(seq_bus.phase)
    );

    always #2 wclk = ~wclk;

    // input window for a column, samples differ per position
    function automatic logic [D-1:0][W-1:0] gen_window(int ch, int col);
        logic [D-1:0][W-1:0] w;
        for (int i = 0; i < D; i++)
            w[i] = W'(col * 16 + i * 3 + ch * 100);
        return w;
    endfunction

    function automatic logic [7:0] model_out(int ch, int col);
        return 8'(ch * 37 + col * 11 + 5);
    endfunction

    // reference window with zero padding at both ends of the row
    function automatic logic [D-1:0][W-1:0] exp_window(logic [D-1:0][W-1:0] win, int col);
        logic [D-1:0][W-1:0] e;
        for (int i = 0; i < D; i++) begin
            if (col == 0)
                e[i] = (i < `ENC_PAD_PRE) ? '0 : win[i - `ENC_PAD_PRE];
            else if (col == LO - 1)
                e[i] = (i >= D - `ENC_PAD_POST) ? '0 : win[i];
            else
                e[i] = win[i];
        end
        return e;
    endfunction

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        chk_cnt++;
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // sram with one cycle read latency, data driven on the falling edge
    always @(posedge wclk) if (sram_en) rd_addr_q <= sram_addr;
    always @(negedge wclk) sram_dout <= mem[rd_addr_q];

    // datapath result and next window go out on the falling edge
    always @(negedge wclk) begin
        encoder_out <= out_nxt;
        window_in   <= win_nxt;
    end

    // checks sample the settled values just before each rising edge
    always @(posedge wclk) begin
        if (rst_n) begin
            cyc++;
            if (spad_w_we) begin
                check_val("spad_w_addr", 128'(spad_w_addr), 128'(wk));
                check_val("spad_w_data", 128'($unsigned(spad_w_data)),
                          128'(mem[(int'(w_base) + ch_i * K + wk) % (1 << `ENC_SRAM_AW)]));
                wk++;
            end
            if (mac_op == enc_pkg::op_acc) begin
                if (acc_cnt == 0) begin
                    check_val("bias", 128'($unsigned(bias)),
                              128'(mem[(int'(b_base) + ch_i) % (1 << `ENC_SRAM_AW)]));
                    check_val("scale", 128'($unsigned(scale)), 128'(mem[scale_addr][15:0]));
                    check_val("window", 128'(window), 128'(exp_window(window_in, col_i)));
                    check_val("shift_en", 128'(shift_en),
                              128'((col_i == 0) ? enc_pkg::sh_first :
                                   (col_i == LO - 1) ? enc_pkg::sh_last : enc_pkg::sh_step));
                end
                check_val("spad_rd_addr", 128'(spad_rd_addr),
                          128'((acc_cnt < K - 1) ? acc_cnt : K - 1));
                acc_cnt++;
            end
            if (mac_op == enc_pkg::op_add_bias) begin
                check_val("acc cycle count", 128'(acc_cnt), 128'(K + 1));
                acc_cnt = 0;
            end
            if (mac_op == enc_pkg::op_requant) begin
                check_val("op before requant", 128'(prev_op), 128'(enc_pkg::op_add_bias));
                out_nxt = model_out(ch_i, col_i);
                exp_q.push_back(model_out(ch_i, col_i));
                if (col_i == LO - 1) begin
                    col_i = 0;
                    wk = 0;
                    if (ch_i == CH - 1) begin
                        last_rq_cyc = cyc;
                        ch_i = 0;   // next start begins at channel 0
                    end else begin
                        ch_i++;
                    end
                end else begin
                    col_i++;
                end
                win_nxt = gen_window(ch_i, col_i);
            end
            check_val("relu_en", 128'(relu_en), 128'(prev_op == enc_pkg::op_add_bias));
            check_val("round_en", 128'(round_en), 128'(prev_op == enc_pkg::op_requant));
            check_val("out_vld", 128'(out_vld), 128'(prev_op == enc_pkg::op_requant));
            prev_op = mac_op;
            if (act_we) begin
                if (exp_q.size() == 0) begin
                    $display("Activation write at %0t with no result pending", $time);
                    err_cnt++;
                end else begin
                    check_val("act_din", 128'(act_din), 128'(exp_q.pop_front()));
                end
                check_val("act_addr", 128'(act_addr), 128'(`ENC_ACT_BASE + wr_cnt));
                wr_cnt++;
            end
            if (encoder_done) begin
                check_val("encoder_done cycle", 128'(cyc), 128'(last_rq_cyc + 2));
                done_cnt++;
            end
        end
    end

    initial begin
        for (int a = 0; a < (1 << `ENC_SRAM_AW); a++)
            mem[a] = $random(seed);
        rst_n = 1'b0;
        start = 1'b0;
        w_base = 10'h010;
        b_base = 10'h200;
        scale_addr = 10'h3f0;
        sram_dout = '0;
        rd_addr_q = '0;
        encoder_out = '0;
        out_nxt = '0;
        window_in = gen_window(0, 0);
        win_nxt = gen_window(0, 0);
        prev_op = enc_pkg::op_none;
        cyc = 0;
        repeat (16) @(posedge wclk);
        @(negedge wclk) rst_n = 1'b1;
        for (int r = 0; r < RUNS; r++) begin
            repeat (3) @(negedge wclk);
            ch_i = 0;
            col_i = 0;
            wk = 0;
            acc_cnt = 0;
            wr_cnt = 0;
            start = 1'b1;
            @(negedge wclk) start = 1'b0;
            wait (done_cnt == r + 1);
            repeat (4) @(negedge wclk);
            check_val("write count", 128'(wr_cnt), 128'(CH * LO));
            check_val("done count", 128'(done_cnt), 128'(r + 1));
        end
        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // two full runs plus margin
    initial begin
        #((RUNS * RUN_CYC + 500) * 4);
        $display("timeout, encoder never finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/enc_pkg.sv
rtl/enc_seq_if.sv
rtl/enc_sequencer.sv
rtl/enc_wb_loader.sv
rtl/enc_act_loader.sv
rtl/enc_writeback.sv
rtl/enc_top.sv
verif/enc_sva.sv
verif/enc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= enc_tb
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
